// File: rtl/pa_config.svh
`ifndef PA_CONFIG_SVH
`define PA_CONFIG_SVH

// ----------------------------------------------------------
// datapath widths
// ----------------------------------------------------------
`define PA_KEY_W          64    // key and secret word
`define PA_MSG_W          32    // message word toward bob
`define PA_KEY_AW         9     // two halves of 256 words each
`define PA_RAND_AW        8
`define PA_SK_AW          8     // two halves of 128 words each

// ----------------------------------------------------------
// run control and message layout
// ----------------------------------------------------------
`define PA_MAX_KEY_WORDS  128   // longest legal reconciled key
`define PA_START_FIRE     128   // held-high cycles before the run starts
`define PA_START_SAT      255   // counter parks here until reset
`define PA_MSG_WORDS      3     // length, index, fold
`define PA_FIFO_DEPTH     8     // power of two, pointers wrap naturally
`define PA_MSG_AW         4

`endif

// File: rtl/pa_pkg.sv
`include "pa_config.svh"

package pa_pkg;

    typedef logic [`PA_KEY_W-1:0]   key_word_t;
    typedef logic [`PA_MSG_W-1:0]   msg_word_t;

    typedef logic [`PA_KEY_AW-1:0]  key_addr_t;   // {index, word number}
    typedef logic [`PA_RAND_AW-1:0] rand_addr_t;
    typedef logic [`PA_SK_AW-1:0]   sk_addr_t;    // {index, output number}
    typedef logic [`PA_MSG_AW-1:0]  msg_addr_t;

    // privacy amplification engine
    typedef enum logic [2:0] {st_idle, st_check, st_hash, st_write, st_push, st_done} pa_state_t;

    // message packer
    typedef enum logic [1:0] {pk_wait_data, pk_claim, pk_copy, pk_notify} pack_state_t;

endpackage

// File: rtl/pa_fifo_if.sv
`timescale 1ns/10ps

// message words from the engine to the packer
interface pa_fifo_if;

    logic              wr_en;
    pa_pkg::msg_word_t wr_data;
    logic              full;     // writer holds off while set
    logic              rd_en;    // pops the head word
    pa_pkg::msg_word_t rd_data;  // head word, valid while empty is low
    logic              empty;

    // producer and consumer sides
    modport writer  (output wr_en, output wr_data, input full);
    modport reader  (output rd_en, input rd_data, input empty);

    // the buffer itself
    modport fifo_wr (input wr_en, input wr_data, output full);
    modport fifo_rd (input rd_en, output rd_data, output empty);

endinterface

// File: rtl/pa_sync_fifo.sv
`timescale 1ns/10ps
`include "pa_config.svh"

module pa_sync_fifo (
    input  logic       clk,
    input  logic       rst_n,
    pa_fifo_if.fifo_wr wr_side,
    pa_fifo_if.fifo_rd rd_side
);

    localparam int PTR_W = $clog2(`PA_FIFO_DEPTH);

    pa_pkg::msg_word_t mem [`PA_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;    // one extra bit to tell full from empty
    logic              do_wr;
    logic              do_rd;

    assign do_wr = wr_side.wr_en && !wr_side.full;
    assign do_rd = rd_side.rd_en && !rd_side.empty;

    assign wr_side.full    = (count == (PTR_W+1)'(`PA_FIFO_DEPTH));
    assign rd_side.empty   = (count == '0);
    assign rd_side.rd_data = mem[rd_ptr];   // show-ahead head word

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_side.wr_data;
    end

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // idle or simultaneous push/pop
            endcase
        end
    end

endmodule

// File: rtl/pa_engine.sv
`timescale 1ns/10ps
`include "pa_config.svh"

module pa_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_switch,
    input  logic [31:0]         secretkey_length,
    input  logic                reconciled_key_addr_index,
    output pa_pkg::key_addr_t   key_addr,
    output logic                key_en,
    input  pa_pkg::key_word_t   key_data,
    output pa_pkg::rand_addr_t  rand_addr,
    output logic                rand_en,
    input  pa_pkg::key_word_t   rand_data,
    output logic                sk_we,
    output pa_pkg::sk_addr_t    sk_addr,
    output pa_pkg::key_word_t   sk_data,
    output logic                pa_finish,
    output logic                pa_fail,
    pa_fifo_if.writer           fifo
);

    pa_pkg::pa_state_t         state;
    logic [7:0]                start_cnt;
    logic                      start_fire;
    logic                      len_ok;
    logic                      key_idx;    // latched address half
    logic [`PA_KEY_AW-2:0]     key_len;    // L
    logic [`PA_SK_AW-2:0]      out_len;    // M
    logic [`PA_KEY_AW-2:0]     i_cnt;      // key word being issued
    logic [`PA_SK_AW-2:0]      j_cnt;      // output word being built
    logic [1:0]                push_cnt;
    logic                      last_push;
    logic                      rd_vld;     // read data arrives this cycle
    logic                      rd_first;   // ... and it is word 0 of a new sum
    pa_pkg::key_word_t         acc;
    pa_pkg::key_word_t         acc_next;
    pa_pkg::msg_word_t         fold;

    // ----------------------------------------------------------
    // start trigger
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= '0;
        end else if (start_switch && start_cnt != 8'(`PA_START_SAT)) begin
            start_cnt <= start_cnt + 1'b1;   // parks at saturation for one fire per reset
        end
    end

    assign start_fire = start_switch && (start_cnt == 8'(`PA_START_FIRE - 1));
    assign len_ok     = (secretkey_length != '0) && (secretkey_length <= `PA_MAX_KEY_WORDS);

    // ----------------------------------------------------------
    // read issue and accumulate
    // ----------------------------------------------------------
    assign key_en    = (state == pa_pkg::st_hash);   // one address per cycle
    assign rand_en   = key_en;
    assign key_addr  = {key_idx, i_cnt};
    assign rand_addr = i_cnt + {1'b0, j_cnt};        // toeplitz diagonal i+j
    assign acc_next  = (rd_first ? '0 : acc) ^ (key_data & rand_data);

    // message push order is length then index then fold
    assign last_push  = (push_cnt == 2'(`PA_MSG_WORDS - 1));
    assign fifo.wr_en = (state == pa_pkg::st_push) && !fifo.full;

    always_comb begin
        case (push_cnt)
            2'd0:    fifo.wr_data = pa_pkg::msg_word_t'(key_len);
            2'd1:    fifo.wr_data = pa_pkg::msg_word_t'(key_idx);
            default: fifo.wr_data = fold;
        endcase
    end

    // ----------------------------------------------------------
    // control fsm
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= pa_pkg::st_idle;
            i_cnt     <= '0;
            j_cnt     <= '0;
            push_cnt  <= '0;
            rd_vld    <= 1'b0;
            rd_first  <= 1'b0;
            sk_we     <= 1'b0;
            pa_finish <= 1'b0;
            pa_fail   <= 1'b0;
        end else begin
            sk_we     <= 1'b0;   // single-cycle strobes
            pa_finish <= 1'b0;
            pa_fail   <= 1'b0;
            rd_vld    <= key_en;
            rd_first  <= key_en && (i_cnt == '0);
            case (state)
                pa_pkg::st_idle: if (start_fire) state <= pa_pkg::st_check;
                pa_pkg::st_check: begin
                    i_cnt    <= '0;
                    j_cnt    <= '0;
                    push_cnt <= '0;
                    if (len_ok) begin
                        state <= pa_pkg::st_hash;
                    end else begin
                        pa_fail <= 1'b1;   // bad length writes nothing
                        state   <= pa_pkg::st_done;
                    end
                end
                pa_pkg::st_hash: begin
                    i_cnt <= i_cnt + 1'b1;
                    if (i_cnt == key_len - 1'b1) state <= pa_pkg::st_write;
                end
                pa_pkg::st_write: begin   // last product lands here
                    i_cnt <= '0;
                    sk_we <= 1'b1;
                    if (j_cnt == out_len - 1'b1) begin
                        state <= pa_pkg::st_push;
                    end else begin
                        j_cnt <= j_cnt + 1'b1;
                        state <= pa_pkg::st_hash;
                    end
                end
                pa_pkg::st_push: begin
                    if (fifo.wr_en) begin   // stalls while fifo is full
                        push_cnt <= push_cnt + 1'b1;
                        if (last_push) begin
                            pa_finish <= 1'b1;
                            state     <= pa_pkg::st_done;
                        end
                    end
                end
                default: state <= pa_pkg::st_idle;
            endcase
        end
    end

    // run parameters, hash sum and secret word
    always_ff @(posedge clk) begin
        if (rd_vld) acc <= acc_next;
        if (state == pa_pkg::st_check) begin
            key_idx <= reconciled_key_addr_index;
            key_len <= secretkey_length[`PA_KEY_AW-2:0];
            out_len <= (secretkey_length[`PA_SK_AW-1:1] == '0)
                       ? (`PA_SK_AW-1)'(1) : secretkey_length[`PA_SK_AW-1:1];
            fold    <= '0;
        end
        if (state == pa_pkg::st_write) begin
            sk_data <= acc_next;
            sk_addr <= {key_idx, j_cnt};
            fold    <= fold ^ acc_next[`PA_KEY_W-1:`PA_MSG_W] ^ acc_next[`PA_MSG_W-1:0];
        end
    end

endmodule

// File: rtl/msg_packer.sv
`timescale 1ns/10ps
`include "pa_config.svh"

module msg_packer (
    input  logic              clk,
    input  logic              rst_n,
    pa_fifo_if.reader         fifo,
    input  logic              busy_net2pp,
    output logic              busy_pp2net,
    output logic              msg_stored,
    output pa_pkg::msg_addr_t msg_size,
    output logic              buf_we,
    output pa_pkg::msg_addr_t buf_addr,
    output pa_pkg::msg_word_t buf_data
);

    pa_pkg::pack_state_t state;
    pa_pkg::msg_addr_t   word_cnt;   // next buffer slot
    logic                copy_go;

    // one word moves per cycle while the fifo has data
    assign copy_go     = (state == pa_pkg::pk_copy) && !fifo.empty;
    assign fifo.rd_en  = copy_go;
    assign buf_we      = copy_go;
    assign buf_addr    = word_cnt;
    assign buf_data    = fifo.rd_data;

    // ----------------------------------------------------------
    // ownership handshake toward the network side
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= pa_pkg::pk_wait_data;
            word_cnt    <= '0;
            busy_pp2net <= 1'b0;
            msg_stored  <= 1'b0;
            msg_size    <= '0;
        end else begin
            msg_stored <= 1'b0;
            case (state)
                pa_pkg::pk_wait_data: begin
                    if (!fifo.empty) state <= pa_pkg::pk_claim;
                end
                pa_pkg::pk_claim: begin
                    if (!busy_net2pp) begin   // buffer free, take it
                        busy_pp2net <= 1'b1;
                        word_cnt    <= '0;
                        state       <= pa_pkg::pk_copy;
                    end
                end
                pa_pkg::pk_copy: begin
                    if (copy_go) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == pa_pkg::msg_addr_t'(`PA_MSG_WORDS - 1))
                            state <= pa_pkg::pk_notify;
                    end
                end
                default: begin   // notify, hand the buffer back
                    msg_size    <= pa_pkg::msg_addr_t'(`PA_MSG_WORDS);
                    busy_pp2net <= 1'b0;
                    msg_stored  <= 1'b1;
                    state       <= pa_pkg::pk_wait_data;
                end
            endcase
        end
    end

endmodule

// File: rtl/msg_buffer.sv
`timescale 1ns/10ps
`include "pa_config.svh"

module msg_buffer (
    input  logic              clk,
    input  logic              we,
    input  pa_pkg::msg_addr_t waddr,
    input  pa_pkg::msg_word_t wdata,
    input  pa_pkg::msg_addr_t raddr,
    output pa_pkg::msg_word_t rdata
);

    // ----------------------------------------------------------
    // simple dual-port ram, packer writes and network reads
    // ----------------------------------------------------------
    pa_pkg::msg_word_t mem [1 << `PA_MSG_AW];

    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: rtl/alice_pp.sv
`timescale 1ns/10ps

module alice_pp (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_switch,
    input  logic [31:0]        secretkey_length,
    input  logic               reconciled_key_addr_index,
    // reconciled key and random word memories
    output pa_pkg::key_addr_t  key_addr,
    output logic               key_en,
    input  pa_pkg::key_word_t  key_data,
    output pa_pkg::rand_addr_t rand_addr,
    output logic               rand_en,
    input  pa_pkg::key_word_t  rand_data,
    // secret key memory
    output logic               sk_we,
    output pa_pkg::sk_addr_t   sk_addr,
    output pa_pkg::key_word_t  sk_data,
    output logic               pa_finish,
    output logic               pa_fail,
    // network side of the message buffer
    input  logic               busy_net2pp,
    output logic               busy_pp2net,
    output logic               msg_stored,
    output pa_pkg::msg_addr_t  msg_size,
    input  pa_pkg::msg_addr_t  msg_addr,
    output pa_pkg::msg_word_t  msg_data
);

    logic              buf_we;
    pa_pkg::msg_addr_t buf_addr;
    pa_pkg::msg_word_t buf_data;

    pa_fifo_if u_fifo_if ();   // engine to packer

    // ----------------------------------------------------------
    // hash engine and message path
    // ----------------------------------------------------------
    pa_engine u_pa_engine (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .start_switch              (start_switch),
        .secretkey_length          (secretkey_length),
        .reconciled_key_addr_index (reconciled_key_addr_index),
        .key_addr                  (key_addr),
        .key_en                    (key_en),
        .key_data                  (key_data),
        .rand_addr                 (rand_addr),
        .rand_en                   (rand_en),
        .rand_data                 (rand_data),
        .sk_we                     (sk_we),
        .sk_addr                   (sk_addr),
        .sk_data                   (sk_data),
        .pa_finish                 (pa_finish),
        .pa_fail                   (pa_fail),
        .fifo                      (u_fifo_if.writer)
    );

    pa_sync_fifo u_pa_sync_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_side (u_fifo_if.fifo_wr),
        .rd_side (u_fifo_if.fifo_rd)
    );

    msg_packer u_msg_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .fifo        (u_fifo_if.reader),
        .busy_net2pp (busy_net2pp),
        .busy_pp2net (busy_pp2net),
        .msg_stored  (msg_stored),
        .msg_size    (msg_size),
        .buf_we      (buf_we),
        .buf_addr    (buf_addr),
        .buf_data    (buf_data)
    );

    msg_buffer u_msg_buffer (
        .clk   (clk),
        .we    (buf_we),
        .waddr (buf_addr),
        .wdata (buf_data),
        .raddr (msg_addr),
        .rdata (msg_data)
    );

endmodule

// File: test/tb_alice_pp.sv
`timescale 1ns/10ps
`include "pa_config.svh"

module tb_alice_pp;

    localparam int NUM_RUNS    = 10;
    localparam int RUN_CYCLES  = 600 + (`PA_MAX_KEY_WORDS / 2) * (`PA_MAX_KEY_WORDS + 1);
    localparam int CYCLE_LIMIT = NUM_RUNS * RUN_CYCLES;   // worst case with every run at full length
    localparam int KEY_HALF    = 1 << (`PA_KEY_AW - 1);
    localparam int SK_HALF     = 1 << (`PA_SK_AW - 1);

    logic               clk;
    logic               rst_n;
    logic               start_switch;
    logic [31:0]        secretkey_length;
    logic               reconciled_key_addr_index;
    pa_pkg::key_addr_t  key_addr;
    logic               key_en;
    pa_pkg::key_word_t  key_data = '0;
    pa_pkg::rand_addr_t rand_addr;
    logic               rand_en;
    pa_pkg::key_word_t  rand_data = '0;
    logic               sk_we;
    pa_pkg::sk_addr_t   sk_addr;
    pa_pkg::key_word_t  sk_data;
    logic               pa_finish;
    logic               pa_fail;
    logic               busy_net2pp;
    logic               busy_pp2net;
    logic               msg_stored;
    pa_pkg::msg_addr_t  msg_size;
    pa_pkg::msg_addr_t  msg_addr;
    pa_pkg::msg_word_t  msg_data;

    pa_pkg::key_word_t key_mem  [1 << `PA_KEY_AW];
    pa_pkg::key_word_t rand_mem [1 << `PA_RAND_AW];
    pa_pkg::key_word_t exp_sk   [`PA_MAX_KEY_WORDS / 2];   // model output words
    pa_pkg::msg_word_t exp_fold;
    logic              exp_idx;
    int                exp_m = 0;
    integer            seed;
    int cycles = 0;
    int mon_errors = 0;     // from the output monitor
    int seq_errors = 0;     // from the run sequence
    int sk_total = 0;
    int finish_total = 0;
    int fail_total = 0;
    int stored_total = 0;
    int rd_total = 0;       // cycles with key_en high
    int sk_base = 0;
    logic pp_prev = 1'b0;
    logic net_prev = 1'b0;

    alice_pp u_alice_pp (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // key and random memories with one cycle read
    always @(posedge clk) begin
        if (key_en) key_data <= key_mem[key_addr];
        if (rand_en) rand_data <= rand_mem[rand_addr];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT never finished its run", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // output monitor sampling mid-cycle
    // ----------------------------------------------------------
    always @(negedge clk) begin : watch_outputs
        int j;
        if (rst_n) begin
            if (key_en) rd_total++;
            if (pa_finish) finish_total++;
            if (pa_fail) fail_total++;
            if (sk_we) begin
                j = sk_total - sk_base;   // output number within this run
                sk_total++;
                assert (j < exp_m) else begin
                    mon_errors++;
                    $display("CHECK FAILED at %0t: extra secret-key write %0d", $time, j);
                end
                if (j < exp_m) begin
                    assert (sk_addr == pa_pkg::sk_addr_t'((exp_idx ? SK_HALF : 0) + j)) else begin
                        mon_errors++;
                        $display("CHECK FAILED at %0t: sk_addr %0d for word %0d", $time, sk_addr, j);
                    end
                    assert (sk_data == exp_sk[j]) else begin
                        mon_errors++;
                        $display("CHECK FAILED at %0t: sk_data %h, expected %h", $time,
                                 sk_data, exp_sk[j]);
                    end
                end
            end
            if (msg_stored) begin
                stored_total++;
                assert (msg_size == pa_pkg::msg_addr_t'(`PA_MSG_WORDS)) else begin
                    mon_errors++;
                    $display("CHECK FAILED at %0t: msg_size %0d", $time, msg_size);
                end
            end
            // a claim is made on the value of busy_net2pp before the edge
            if (busy_pp2net && !pp_prev) begin
                assert (!net_prev) else begin
                    mon_errors++;
                    $display("CHECK FAILED at %0t: busy_pp2net rose while net owns buffer", $time);
                end
            end
        end
        pp_prev  <= busy_pp2net;
        net_prev <= busy_net2pp;
    end

    // ----------------------------------------------------------
    // reference model and run sequence
    // ----------------------------------------------------------
    task automatic build_model(input int len, input logic idx);
        pa_pkg::key_word_t sum;
        exp_idx  = idx;
        exp_m    = (len / 2 < 1) ? 1 : len / 2;
        exp_fold = '0;
        for (int j = 0; j < exp_m; j++) begin
            sum = '0;
            for (int i = 0; i < len; i++)
                sum ^= key_mem[(idx ? KEY_HALF : 0) + i] & rand_mem[i + j];
            exp_sk[j] = sum;
            exp_fold ^= sum[63:32] ^ sum[31:0];   // upper half folded onto lower
        end
    endtask

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            seq_errors++;
            $display("CHECK FAILED at %0t: %s", $time, what);
        end
    endtask

    task automatic apply_reset(input logic hold_busy);
        @(posedge clk);
        rst_n        <= 1'b0;
        start_switch <= 1'b0;
        busy_net2pp  <= hold_busy;
        msg_addr     <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(!pa_finish && !pa_fail && !sk_we && !key_en && !rand_en, "strobes set after reset");
        check(!busy_pp2net && !msg_stored && msg_size == '0, "handshake set after reset");
    endtask

    task automatic pulse_start(input int high_cycles, input int low_cycles);
        @(posedge clk) start_switch <= 1'b1;
        repeat (high_cycles) @(posedge clk);
        start_switch <= 1'b0;
        repeat (low_cycles) @(posedge clk);
    endtask

    task automatic read_word(input int addr, input pa_pkg::msg_word_t expected);
        @(posedge clk) msg_addr <= pa_pkg::msg_addr_t'(addr);
        @(posedge clk);
        @(negedge clk);
        assert (msg_data == expected) else begin
            seq_errors++;
            $display("CHECK FAILED at %0t: msg word %0d is %h, expected %h", $time, addr,
                     msg_data, expected);
        end
    endtask

    task automatic do_run(input int len, input logic idx, input logic hold_busy);
        int   run_start;
        int   fail_start;
        int   stored_start;
        int   rd_start;
        logic legal;
        legal = (len > 0) && (len <= `PA_MAX_KEY_WORDS);
        if (legal) begin
            build_model(len, idx);
        end else begin
            exp_idx = idx;
            exp_m   = 0;   // no writes allowed
        end
        apply_reset(hold_busy);
        sk_base      = sk_total;
        run_start    = finish_total + fail_total;
        fail_start   = fail_total;
        stored_start = stored_total;
        rd_start     = rd_total;
        @(posedge clk);
        secretkey_length          <= len;
        reconciled_key_addr_index <= idx;
        pulse_start(60, 15);
        pulse_start(67, 15);   // 127 high cycles in all is one short of firing
        @(negedge clk);
        check(rd_total == rd_start && finish_total + fail_total == run_start, "started early");
        @(posedge clk) start_switch <= 1'b1;   // stays high for the rest of the run
        @(posedge clk);                        // start fires on the 128th high cycle
        @(negedge clk);
        check(!key_en && !pa_fail, "length check took no cycle");
        @(posedge clk);
        @(negedge clk);
        check(legal ? key_en : pa_fail, "run did not begin one cycle after the start");
        while (finish_total + fail_total == run_start) @(posedge clk);
        if (legal) begin
            check(fail_total == fail_start, "pa_fail on a legal length");
            check(sk_total - sk_base == exp_m, "wrong number of secret-key writes");
            check(rd_total - rd_start == exp_m * len, "wrong number of reads");
            if (hold_busy) begin
                repeat (20) @(posedge clk);
                @(negedge clk);
                check(!busy_pp2net && stored_total == stored_start, "packer ignored busy_net2pp");
                @(posedge clk) busy_net2pp <= 1'b0;
            end
            while (stored_total == stored_start) @(posedge clk);
            read_word(0, len);
            read_word(1, {31'b0, idx});
            read_word(2, exp_fold);
        end
        repeat (`PA_START_SAT + 8) @(posedge clk);   // start_switch high past a counter wrap
        check(finish_total + fail_total == run_start + 1, "not exactly one run per reset");
        check(stored_total - stored_start == (legal ? 1 : 0), "wrong number of msg_stored");
        check(sk_total - sk_base == exp_m, "secret-key writes after the run");
        start_switch <= 1'b0;
    endtask

    initial begin
        int len;
        seed                      = 97108;
        rst_n                     = 1'b0;
        start_switch              = 1'b0;
        secretkey_length          = '0;
        reconciled_key_addr_index = 1'b0;
        busy_net2pp               = 1'b0;
        msg_addr                  = '0;
        for (int a = 0; a < (1 << `PA_KEY_AW); a++) key_mem[a] = {$random(seed), $random(seed)};
        for (int a = 0; a < (1 << `PA_RAND_AW); a++) rand_mem[a] = {$random(seed), $random(seed)};

        do_run(0, 1'b0, 1'b0);     // illegal lengths first
        do_run(129, 1'b1, 1'b0);
        do_run(`PA_MAX_KEY_WORDS, 1'b1, 1'b1);
        do_run(1, 1'b0, 1'b0);
        for (int r = 0; r < NUM_RUNS - 4; r++) begin
            len = ($unsigned($random(seed)) % `PA_MAX_KEY_WORDS) + 1;
            do_run(len, r[0], (r % 3) == 0);
        end

        $display("monitor errors: %0d, sequence errors: %0d, total: %0d", mon_errors,
                 seq_errors, mon_errors + seq_errors);
        if (mon_errors + seq_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: alice_pp.f
+incdir+rtl
rtl/pa_pkg.sv
rtl/pa_fifo_if.sv
rtl/pa_sync_fifo.sv
rtl/pa_engine.sv
rtl/msg_packer.sv
rtl/msg_buffer.sv
rtl/alice_pp.sv
test/tb_alice_pp.sv

// File: Makefile
TOP = tb_alice_pp

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f alice_pp.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f alice_pp.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
